// File: verilog/rv32i_pkg.sv
package rv32i_pkg;

	typedef logic [31:0] word_t;     // data or address word
	typedef logic [4:0]  reg_idx_t;  // architectural register index

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		op_csr   = 7'b1110011
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt,
		alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and,
		alu_pass_b  // lui, result is operand b
	} alu_op_t;

	typedef struct packed {
		word_t    pc;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic     use_rs2;    // operand b from rs2, else from imm
		word_t    imm;
		logic     use_pc_a;   // operand a is the pc (auipc)
		alu_op_t  alu_op;
		logic     writes_rd;  // rd is a real destination, not x0
	} decoded_t;

endpackage

// File: verilog/ooo_pkg.sv
package ooo_pkg;
	import rv32i_pkg::*;

	localparam int rob_size = 8;
	localparam int rs_size  = 4;
	localparam int tag_bits = $clog2(rob_size);

	typedef logic [tag_bits-1:0] tag_t;  // rob index

	typedef struct packed {
		logic  ready;
		tag_t  tag;    // producer still awaited while not ready
		word_t value;
	} operand_t;

	typedef struct packed {
		logic     valid;
		alu_op_t  alu_op;
		tag_t     tag;    // rob entry that gets the result
		operand_t a;
		operand_t b;
	} rs_entry_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t value;
	} cdb_t;

endpackage

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
	import rv32i_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  dispatch,
	input  logic  i_mem_resp,
	input  word_t i_mem_rdata,
	output logic  i_mem_read,
	output word_t i_mem_address,
	output logic  fetch_valid,
	output word_t fetch_word,
	output word_t fetch_pc
);

	word_t pc;
	logic  buf_valid;

	assign i_mem_read    = ~buf_valid;  // one word in flight, only while buffer empty
	assign i_mem_address = pc;
	assign fetch_valid   = buf_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc        <= '0;
			buf_valid <= 1'b0;
		end else if (i_mem_resp) begin
			buf_valid <= 1'b1;
			pc        <= pc + 32'd4;
		end else if (dispatch) begin
			buf_valid <= 1'b0;  // next request goes out the following cycle
		end
	end

	always_ff @(posedge clk) begin
		if (i_mem_resp) begin
			fetch_word <= i_mem_rdata;
			fetch_pc   <= pc;
		end
	end

	// memory may only answer a read that is still outstanding
	a_resp_pending: assert property (@(posedge clk) disable iff (rst) i_mem_resp |-> i_mem_read);

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ps

module decoder
	import rv32i_pkg::*;
(
	input  word_t    fetch_word,
	input  word_t    fetch_pc,
	output decoded_t decoded
);

	opcode_t    opcode;
	logic [2:0] funct3;
	logic       f7_bit5;
	word_t      i_imm;
	word_t      u_imm;
	alu_op_t    f3_op;

	assign opcode  = opcode_t'(fetch_word[6:0]);
	assign funct3  = fetch_word[14:12];
	assign f7_bit5 = fetch_word[30];
	assign i_imm   = {{20{fetch_word[31]}}, fetch_word[31:20]};
	assign u_imm   = {fetch_word[31:12], 12'h000};

	always_comb begin
		case (funct3)
			3'b000:  f3_op = (f7_bit5 && opcode == op_reg) ? alu_sub : alu_add;  // no subi
			3'b001:  f3_op = alu_sll;
			3'b010:  f3_op = alu_slt;
			3'b011:  f3_op = alu_sltu;
			3'b100:  f3_op = alu_xor;
			3'b101:  f3_op = f7_bit5 ? alu_sra : alu_srl;
			3'b110:  f3_op = alu_or;
			default: f3_op = alu_and;
		endcase
	end

	always_comb begin
		decoded        = '0;
		decoded.pc     = fetch_pc;
		decoded.alu_op = alu_add;
		case (opcode)
			op_reg: begin
				decoded.rd      = fetch_word[11:7];
				decoded.rs1     = fetch_word[19:15];
				decoded.rs2     = fetch_word[24:20];
				decoded.use_rs2 = 1'b1;
				decoded.alu_op  = f3_op;
			end
			op_imm: begin
				decoded.rd     = fetch_word[11:7];
				decoded.rs1    = fetch_word[19:15];
				decoded.imm    = i_imm;  // shamt sits in imm[4:0]
				decoded.alu_op = f3_op;
			end
			op_lui: begin
				decoded.rd     = fetch_word[11:7];
				decoded.imm    = u_imm;
				decoded.alu_op = alu_pass_b;
			end
			op_auipc: begin
				decoded.rd       = fetch_word[11:7];
				decoded.imm      = u_imm;
				decoded.use_pc_a = 1'b1;
			end
			default: ;  // anything else goes down the pipe as an x0 no-op
		endcase
		decoded.writes_rd = decoded.rd != '0;
	end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile
	import rv32i_pkg::*;
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  logic     dispatch,
	input  tag_t     alloc_tag,
	input  logic     commit_valid,
	input  reg_idx_t commit_rd,
	input  tag_t     commit_tag,
	input  word_t    commit_data,
	output logic     rs1_busy,
	output tag_t     rs1_tag,
	output word_t    rs1_value,
	output logic     rs2_busy,
	output tag_t     rs2_tag,
	output word_t    rs2_value
);

	word_t regs [32];
	logic  busy [32];
	tag_t  tags [32];  // youngest in-flight producer of each register

	assign rs1_busy  = busy[rs1];
	assign rs1_tag   = tags[rs1];
	assign rs1_value = regs[rs1];
	assign rs2_busy  = busy[rs2];
	assign rs2_tag   = tags[rs2];
	assign rs2_value = regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
				busy[i] <= 1'b0;
				tags[i] <= '0;
			end
		end else begin
			if (commit_valid && commit_rd != '0) begin
				regs[commit_rd] <= commit_data;
				if (tags[commit_rd] == commit_tag) begin
					busy[commit_rd] <= 1'b0;  // no younger writer pending
				end
			end
			if (dispatch && rd != '0) begin  // x0 stays zero and never busy
				busy[rd] <= 1'b1;
				tags[rd] <= alloc_tag;
			end
		end
	end

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
	import rv32i_pkg::*;
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     fetch_valid,
	input  logic     rs_full,
	input  decoded_t decoded,
	input  logic     rs1_busy,
	input  tag_t     rs1_tag,
	input  word_t    rs1_value,
	input  logic     rs2_busy,
	input  tag_t     rs2_tag,
	input  word_t    rs2_value,
	input  cdb_t     cdb,
	output logic     dispatch,
	output tag_t     alloc_tag,
	output operand_t op_a,
	output operand_t op_b,
	output logic     commit_valid,
	output tag_t     commit_tag,
	output word_t    commit_pc,
	output reg_idx_t commit_rd,
	output word_t    commit_data
);

	tag_t              head;
	tag_t              tail;
	logic [tag_bits:0] count;
	logic              full;
	logic              done    [rob_size];
	word_t             value_q [rob_size];
	word_t             pc_q    [rob_size];
	reg_idx_t          rd_q    [rob_size];
	tag_t              cdb_age;

	// register value, finished rob entry, or a same-cycle cdb hit, else wait on the tag
	function automatic operand_t resolve(input logic busy, input tag_t tag, input word_t value,
			input logic entry_done, input word_t entry_value, input cdb_t bus);
		operand_t op;
		op.ready = 1'b1;
		op.tag   = tag;
		op.value = value;
		if (busy) begin
			if (entry_done) begin
				op.value = entry_value;
			end else if (bus.valid && bus.tag == tag) begin
				op.value = bus.value;
			end else begin
				op.ready = 1'b0;
			end
		end
		return op;
	endfunction

	assign full      = count == (tag_bits + 1)'(rob_size);
	assign dispatch  = fetch_valid && !full && !rs_full;
	assign alloc_tag = tail;

	always_comb begin
		op_a = resolve(rs1_busy, rs1_tag, rs1_value, done[rs1_tag], value_q[rs1_tag], cdb);
		op_b = resolve(rs2_busy, rs2_tag, rs2_value, done[rs2_tag], value_q[rs2_tag], cdb);
		if (decoded.use_pc_a) begin
			op_a.ready = 1'b1;
			op_a.value = decoded.pc;
		end
		if (!decoded.use_rs2) begin
			op_b.ready = 1'b1;
			op_b.value = decoded.imm;
		end
	end

	assign commit_valid = count != '0 && done[head];
	assign commit_tag   = head;
	assign commit_pc    = pc_q[head];
	assign commit_rd    = rd_q[head];
	assign commit_data  = value_q[head];
	assign cdb_age      = cdb.tag - head;

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < rob_size; i++) begin
				done[i] <= 1'b0;
			end
		end else begin
			if (dispatch) begin
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;  // commit can take it next cycle
			end
			if (commit_valid) begin
				head <= head + 1'b1;
			end
			case ({dispatch, commit_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch) begin
			pc_q[tail] <= decoded.pc;
			rd_q[tail] <= decoded.writes_rd ? decoded.rd : '0;
		end
		if (cdb.valid) begin
			value_q[cdb.tag] <= cdb.value;
		end
	end

	// the alu only ever broadcasts for an in-flight entry that is still waiting
	a_cdb_tag_live: assert property (@(posedge clk) disable iff (rst)
		cdb.valid |-> (cdb_age < count) && !done[cdb.tag]);

endmodule

// File: verilog/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
	import rv32i_pkg::*;
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      dispatch,
	input  tag_t      alloc_tag,
	input  alu_op_t   alu_op,
	input  operand_t  op_a,
	input  operand_t  op_b,
	input  cdb_t      cdb,
	output logic      rs_full,
	output logic      issue_valid,
	output rs_entry_t issue
);

	rs_entry_t                  slots [rs_size];
	logic [rs_size-1:0]         ready;
	tag_t                       age   [rs_size];
	logic [$clog2(rs_size)-1:0] free_idx;
	logic [$clog2(rs_size)-1:0] pick;
	tag_t                       best_age;

	// distance from the rob tail, the oldest in-flight tag gives the smallest value
	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			ready[i] = slots[i].valid && slots[i].a.ready && slots[i].b.ready;
			age[i]   = slots[i].tag - alloc_tag;
		end
	end

	always_comb begin
		rs_full  = 1'b1;
		free_idx = '0;
		for (int i = rs_size - 1; i >= 0; i--) begin
			if (!slots[i].valid) begin
				rs_full  = 1'b0;
				free_idx = i[$clog2(rs_size)-1:0];  // lowest free slot
			end
		end
	end

	always_comb begin
		issue_valid = 1'b0;
		pick        = '0;
		best_age    = '1;
		for (int i = 0; i < rs_size; i++) begin
			if (ready[i] && (!issue_valid || age[i] < best_age)) begin
				issue_valid = 1'b1;
				pick        = i[$clog2(rs_size)-1:0];
				best_age    = age[i];
			end
		end
	end

	assign issue = slots[pick];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rs_size; i++) begin
				slots[i].valid <= 1'b0;
			end
		end else begin
			for (int i = 0; i < rs_size; i++) begin
				if (cdb.valid && !slots[i].a.ready && slots[i].a.tag == cdb.tag) begin
					slots[i].a.ready <= 1'b1;
					slots[i].a.value <= cdb.value;
				end
				if (cdb.valid && !slots[i].b.ready && slots[i].b.tag == cdb.tag) begin
					slots[i].b.ready <= 1'b1;
					slots[i].b.value <= cdb.value;
				end
			end
			if (issue_valid) begin
				slots[pick].valid <= 1'b0;
			end
			if (dispatch) begin
				slots[free_idx] <= '{valid: 1'b1, alu_op: alu_op, tag: alloc_tag,
					a: op_a, b: op_b};
			end
		end
	end

	// rob must hold dispatch back while every slot is taken
	a_no_load_full: assert property (@(posedge clk) disable iff (rst) dispatch |-> !rs_full);

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
	import rv32i_pkg::*;
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      issue_valid,
	input  rs_entry_t issue,
	output cdb_t      cdb
);

	word_t      a;
	word_t      b;
	logic [4:0] shamt;
	word_t      result;

	assign a     = issue.a.value;
	assign b     = issue.b.value;
	assign shamt = b[4:0];

	always_comb begin
		case (issue.alu_op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_sll:  result = a << shamt;
			alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
			alu_sltu: result = {31'b0, a < b};
			alu_xor:  result = a ^ b;
			alu_srl:  result = a >> shamt;
			alu_sra:  result = word_t'($signed(a) >>> shamt);
			alu_or:   result = a | b;
			alu_and:  result = a & b;
			default:  result = b;  // pass_b
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= issue_valid;  // broadcast one cycle after issue
		end
		cdb.tag   <= issue.tag;
		cdb.value <= result;
	end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu
	import rv32i_pkg::*;
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     i_mem_resp,
	input  word_t    i_mem_rdata,
	output logic     i_mem_read,
	output word_t    i_mem_address,
	output logic     commit_valid,
	output word_t    commit_pc,
	output reg_idx_t commit_rd,
	output word_t    commit_data
);

	logic      fetch_valid;
	word_t     fetch_word;
	word_t     fetch_pc;
	decoded_t  decoded;
	logic      dispatch;
	tag_t      alloc_tag;
	logic      rs1_busy;
	tag_t      rs1_tag;
	word_t     rs1_value;
	logic      rs2_busy;
	tag_t      rs2_tag;
	word_t     rs2_value;
	operand_t  op_a;
	operand_t  op_b;
	logic      rs_full;
	logic      issue_valid;
	rs_entry_t issue;
	cdb_t      cdb;
	tag_t      commit_tag;

	fetch_unit u_fetch (.*);

	decoder u_decoder (.*);

	regfile u_regfile (
		.rs1 (decoded.rs1),
		.rs2 (decoded.rs2),
		.rd  (decoded.rd),
		.*
	);

	reorder_buffer u_rob (.*);

	reservation_station u_rs (
		.alu_op (decoded.alu_op),
		.*
	);

	alu_unit u_alu (.*);

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
	import rv32i_pkg::*;
;

	localparam int trace_len   = 20;
	localparam int idx_bits    = $clog2(trace_len);
	localparam int cycle_limit = 20 * trace_len + 100;
	localparam word_t nop_word = 32'h00000013;  // addi x0, x0, 0

	typedef struct packed {
		word_t    insn;
		reg_idx_t rd;
		word_t    value;
	} trace_entry_t;

	logic     clk;
	logic     rst;
	logic     i_mem_resp;
	word_t    i_mem_rdata;
	logic     i_mem_read;
	word_t    i_mem_address;
	logic     commit_valid;
	word_t    commit_pc;
	reg_idx_t commit_rd;
	word_t    commit_data;

	word_t        raw [3 * trace_len];  // three numbers per trace line
	trace_entry_t prog [trace_len];
	logic [31:0]  lfsr;

	cpu u_cpu (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// idle cycles before the next answer, 0 to 3
	task automatic draw_delay(output int delay);
		logic [1:0] bits;
		for (int i = 0; i < 2; i++) begin
			lfsr    = lfsr_next(lfsr);
			bits[i] = lfsr[0];
		end
		delay = int'(bits);
	endtask

	function automatic word_t mem_word(input word_t addr);
		logic [idx_bits-1:0] idx;
		idx = addr[idx_bits+1:2];
		if (addr[31:2] < 30'(trace_len)) begin
			return prog[idx].insn;
		end
		return nop_word;  // past the program
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "register index mismatch on %s", name);
		end
	endtask

	// instruction memory, answers one outstanding read after a random wait
	initial begin : mem_model
		int    wait_left;
		logic  pending;
		word_t next_addr;
		lfsr        = 32'h38edc615;
		i_mem_resp  = 1'b0;
		i_mem_rdata = '0;
		wait_left   = 0;
		pending     = 1'b0;
		next_addr   = '0;
		@(negedge rst);
		forever begin
			@(negedge clk);
			i_mem_resp = 1'b0;
			if (pending && i_mem_read !== 1'b1) begin
				$display("instruction read was dropped before the memory answered");
				$display("TESTS FAILED");
				$fatal(1, "read request withdrawn");
			end
			if (i_mem_read === 1'b1) begin
				if (!pending) begin
					pending = 1'b1;
					draw_delay(wait_left);
				end
				if (wait_left == 0) begin
					check_word("i_mem_address", i_mem_address, next_addr);  // in-order fetch
					i_mem_resp  = 1'b1;  // one cycle only
					i_mem_rdata = mem_word(i_mem_address);
					pending     = 1'b0;
					next_addr   = next_addr + 32'd4;
				end else begin
					wait_left--;
				end
			end
		end
	end

	initial begin : run_checks
		int    commits;
		int    cycles;
		word_t exp_pc;
		commits = 0;
		cycles  = 0;
		exp_pc  = '0;
		rst     = 1'b1;
		$readmemh("tests/cpu_trace.txt", raw);
		for (int i = 0; i < trace_len; i++) begin
			prog[i].insn  = raw[3 * i];
			prog[i].rd    = raw[3 * i + 1][4:0];
			prog[i].value = raw[3 * i + 2];
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (commits < trace_len) begin
			@(negedge clk);  // commit outputs settle mid-cycle
			cycles++;
			if (cycles > cycle_limit) begin
				$display("timeout: %0d of %0d instructions committed after %0d cycles",
					commits, trace_len, cycles - 1);
				$display("TESTS FAILED");
				$fatal(1, "simulation timed out");
			end
			if (commit_valid) begin
				check_word("commit_pc", commit_pc, exp_pc);
				check_reg("commit_rd", commit_rd, prog[commits].rd);
				check_word("commit_data", commit_data, prog[commits].value);
				exp_pc = exp_pc + 32'd4;
				commits++;
			end
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: tests/cpu_trace.txt
// columns: instruction word, expected rd, expected commit value
// the word on line i sits at address 4*i
00500093 01 00000005  // addi x1, x0, 5
ffd00113 02 fffffffd  // addi x2, x0, -3
002081b3 03 00000002  // add  x3, x1, x2
40208233 04 00000008  // sub  x4, x1, x2
003092b3 05 00000014  // sll  x5, x1, x3
00112333 06 00000001  // slt  x6, x2, x1
001133b3 07 00000000  // sltu x7, x2, x1
0020c433 08 fffffff8  // xor  x8, x1, x2
003154b3 09 3fffffff  // srl  x9, x2, x3
40315533 0a ffffffff  // sra  x10, x2, x3
0040e5b3 0b 0000000d  // or   x11, x1, x4
00817633 0c fffffff8  // and  x12, x2, x8
123456b7 0d 12345000  // lui  x13, 0x12345
00001717 0e 00001034  // auipc x14, 1 at pc 0x34
00708013 00 0000000c  // addi x0, x1, 7
001007b3 0f 00000005  // add  x15, x0, x1
00102023 00 00000000  // sw x1, 0(x0) is not supported
40115813 10 fffffffe  // srai x16, x2, 1
ffe12893 11 00000001  // slti x17, x2, -2
fff0b913 12 00000001  // sltiu x18, x1, -1

// File: vlog.f
verilog/rv32i_pkg.sv
verilog/ooo_pkg.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/cpu.sv
tests/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module cpu_tb -f vlog.f > sim.log 2>&1 &&
	./obj_dir/Vcpu_tb >> sim.log 2>&1 ||
	echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
